//--- hw/rotator_settings.svh
`ifndef ROTATOR_SETTINGS_SVH
`define ROTATOR_SETTINGS_SVH

// Datapath widths
`define SAMPLE_WIDTH 16
`define FRAC_BITS 14

// Twiddle table
`define TWIDDLE_COUNT 24
`define INDEX_WIDTH 5

// Wishbone word addresses
`define WB_ADDR_WIDTH 2
`define ADDR_CTRL 2'd0
`define ADDR_SAMPLE 2'd1
`define ADDR_RESULT 2'd2
`define ADDR_STATUS 2'd3

`endif

//--- hw/rotatorPkg.sv
`default_nettype none

package rotatorPkg;

  `include "rotator_settings.svh"

  typedef struct packed
  {
    logic signed [`SAMPLE_WIDTH-1:0] re;
    logic signed [`SAMPLE_WIDTH-1:0] im;
  } cplxSample;

  // Q1.14 pair, applied as cos - j*sin
  typedef struct packed
  {
    logic signed [`SAMPLE_WIDTH-1:0] cosine;
    logic signed [`SAMPLE_WIDTH-1:0] sine;
  } twiddle;

  typedef struct packed
  {
    logic [30:0] reserved;
    logic clearIndex;
  } ctrlWord;

  // Same write word, meaning picked by address
  typedef union packed
  {
    cplxSample sample;
    ctrlWord ctrl;
  } wbWord;

  typedef struct packed
  {
    logic [25:0] reserved;
    logic busy;
    logic [`INDEX_WIDTH-1:0] index;
  } statusWord;

  typedef struct packed
  {
    logic cyc;
    logic stb;
    logic we;
    logic [`WB_ADDR_WIDTH-1:0] adr;
    wbWord dat;
  } wbReq;

  typedef struct packed
  {
    logic ack;
    logic [31:0] dat;
  } wbRsp;

endpackage

`default_nettype wire

//--- hw/twiddleRom.sv
`default_nettype none

`include "rotator_settings.svh"

module twiddleRom
(
  input wire logic CLK,
  input wire logic ARST,
  input wire logic [`INDEX_WIDTH-1:0] index,
  output rotatorPkg::twiddle tw
);

  // One entry per index, cosine first
  always_ff @(posedge CLK or posedge ARST)
  begin
    if (ARST)
    begin
      tw <= '0;
    end
    else
    begin
      case (index)
        5'd0: tw <= '{cosine: 16'h4000, sine: 16'h0000};
        5'd1: tw <= '{cosine: 16'h1090, sine: 16'h3DD1};
        5'd2: tw <= '{cosine: 16'hC894, sine: 16'h1FFF};
        5'd3: tw <= '{cosine: 16'hD2BF, sine: 16'hD2BF};
        5'd4: tw <= '{cosine: 16'h2000, sine: 16'hC894};
        5'd5: tw <= '{cosine: 16'h3DD1, sine: 16'h1090};
        5'd6: tw <= '{cosine: 16'h0000, sine: 16'h4000};
        5'd7: tw <= '{cosine: 16'hC22F, sine: 16'h1090};
        5'd8: tw <= '{cosine: 16'hE001, sine: 16'hC894};
        5'd9: tw <= '{cosine: 16'h2D41, sine: 16'hD2BF};
        5'd10: tw <= '{cosine: 16'h376C, sine: 16'h1FFF};
        5'd11: tw <= '{cosine: 16'hEF70, sine: 16'h3DD1};
        5'd12: tw <= '{cosine: 16'hC000, sine: 16'h0000};
        5'd13: tw <= '{cosine: 16'hEF70, sine: 16'hC22F};
        5'd14: tw <= '{cosine: 16'h376C, sine: 16'hE000};
        5'd15: tw <= '{cosine: 16'h2D41, sine: 16'h2D41};
        5'd16: tw <= '{cosine: 16'hE000, sine: 16'h376C};
        5'd17: tw <= '{cosine: 16'hC22F, sine: 16'hEF70};
        5'd18: tw <= '{cosine: 16'h0000, sine: 16'hC000};
        5'd19: tw <= '{cosine: 16'h3DD1, sine: 16'hEF70};
        5'd20: tw <= '{cosine: 16'h2000, sine: 16'h376C};
        5'd21: tw <= '{cosine: 16'hD2BF, sine: 16'h2D41};
        5'd22: tw <= '{cosine: 16'hC894, sine: 16'hE001};
        5'd23: tw <= '{cosine: 16'h1090, sine: 16'hC22F};
        default: tw <= '0; // Unused codes 24..31
      endcase
    end
  end

  // Sequencer wrap keeps the ROM inside its table
  a_indexInRange: assert property (
    @(posedge CLK) disable iff (ARST) index < `TWIDDLE_COUNT
  ) else $error("twiddle index %0d beyond table", index);

endmodule

`default_nettype wire

//--- hw/twiddleSequencer.sv
`default_nettype none

`include "rotator_settings.svh"

module twiddleSequencer
(
  input wire logic CLK,
  input wire logic ARST,
  input wire logic advance,
  input wire logic clearIndex,
  output logic [`INDEX_WIDTH-1:0] index
);

  logic atLast;

  assign atLast = (index == `TWIDDLE_COUNT - 1);

  always_ff @(posedge CLK or posedge ARST)
  begin
    if (ARST)
    begin
      index <= '0;
    end
    else if (clearIndex) // Host restart wins
    begin
      index <= '0;
    end
    else if (advance)
    begin
      if (atLast)
      begin
        index <= '0;
      end
      else
      begin
        index <= index + 1'b1;
      end
    end
  end

  // CTRL and SAMPLE writes are acked on different edges
  a_noClearOnAdvance: assert property (
    @(posedge CLK) disable iff (ARST) !(advance && clearIndex)
  ) else $error("clear and advance in the same cycle");

endmodule

`default_nettype wire

//--- hw/complexRotator.sv
`default_nettype none

`include "rotator_settings.svh"

module complexRotator
(
  input wire logic CLK,
  input wire logic ARST,
  input rotatorPkg::cplxSample sample,
  input wire logic sampleValid,
  input rotatorPkg::twiddle tw,
  output rotatorPkg::cplxSample result,
  output logic resultValid,
  output logic busy,
  output logic advance
);

  localparam int SumWidth = 2 * `SAMPLE_WIDTH + 1;
  localparam logic signed [SumWidth-1:0] MaxVal = (1 <<< (`SAMPLE_WIDTH - 1)) - 1;
  localparam logic signed [SumWidth-1:0] MinVal = -(1 <<< (`SAMPLE_WIDTH - 1));

  logic signed [2*`SAMPLE_WIDTH-1:0] prodAC;
  logic signed [2*`SAMPLE_WIDTH-1:0] prodBS;
  logic signed [2*`SAMPLE_WIDTH-1:0] prodBC;
  logic signed [2*`SAMPLE_WIDTH-1:0] prodAS;
  logic s1Valid;
  logic signed [SumWidth-1:0] sumRe;
  logic signed [SumWidth-1:0] sumIm;

  // Truncating shift back to Q15, then clip
  function automatic logic signed [`SAMPLE_WIDTH-1:0] saturate(
    input logic signed [SumWidth-1:0] sum
  );
    logic signed [SumWidth-1:0] shifted;
    shifted = sum >>> `FRAC_BITS;
    if (shifted > MaxVal)
      return MaxVal[`SAMPLE_WIDTH-1:0];
    else if (shifted < MinVal)
      return MinVal[`SAMPLE_WIDTH-1:0];
    else
      return shifted[`SAMPLE_WIDTH-1:0];
  endfunction

  // Index moves on as stage 1 takes the current twiddle
  assign advance = sampleValid;
  assign busy = sampleValid | s1Valid;

  always_ff @(posedge CLK or posedge ARST)
  begin
    if (ARST)
    begin
      s1Valid <= 1'b0;
      resultValid <= 1'b0;
    end
    else
    begin
      s1Valid <= sampleValid;
      resultValid <= s1Valid;
    end
  end

  // Stage 1 products
  always_ff @(posedge CLK)
  begin
    if (sampleValid)
    begin
      prodAC <= sample.re * tw.cosine;
      prodBS <= sample.im * tw.sine;
      prodBC <= sample.im * tw.cosine;
      prodAS <= sample.re * tw.sine;
    end
  end

  // Conjugate twiddle flips the sine terms
  assign sumRe = prodAC + prodBS;
  assign sumIm = prodBC - prodAS;

  always_ff @(posedge CLK)
  begin
    if (s1Valid)
    begin
      result.re <= saturate(sumRe);
      result.im <= saturate(sumIm);
    end
  end

  // Register block must hold off new samples while the pipe is full
  a_noSampleWhileBusy: assert property (
    @(posedge CLK) disable iff (ARST) sampleValid |-> !s1Valid
  ) else $error("sample entered a busy rotator");

endmodule

`default_nettype wire

//--- hw/wbRegs.sv
`default_nettype none

`include "rotator_settings.svh"

module wbRegs
(
  input wire logic CLK,
  input wire logic ARST,
  input rotatorPkg::wbReq req,
  output rotatorPkg::wbRsp rsp,
  input wire logic [`INDEX_WIDTH-1:0] index,
  input rotatorPkg::cplxSample result,
  input wire logic resultValid,
  input wire logic busy,
  output rotatorPkg::cplxSample sample,
  output logic sampleValid,
  output logic clearIndex
);

  import rotatorPkg::*;

  logic ack;
  logic [31:0] rdData;
  logic accept;
  logic sampleWrite;
  logic ctrlWrite;
  cplxSample resultReg;
  statusWord status;

  // New transfer only when the previous ack has gone
  assign accept = req.cyc & req.stb & ~ack;
  assign sampleWrite = accept & req.we & (req.adr == `ADDR_SAMPLE);
  assign ctrlWrite = accept & req.we & (req.adr == `ADDR_CTRL);

  assign status.reserved = '0;
  assign status.busy = busy;
  assign status.index = index;

  assign rsp.ack = ack;
  assign rsp.dat = rdData;

  always_ff @(posedge CLK or posedge ARST)
  begin
    if (ARST)
    begin
      ack <= 1'b0;
      sampleValid <= 1'b0;
      clearIndex <= 1'b0;
      resultReg <= '0;
    end
    else
    begin
      ack <= accept;
      sampleValid <= sampleWrite & ~busy; // Dropped while rotating
      clearIndex <= ctrlWrite & req.dat.ctrl.clearIndex;
      if (resultValid)
      begin
        resultReg <= result;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (sampleWrite && !busy)
    begin
      sample <= req.dat.sample;
    end
  end

  // Read data captured on the accepting edge
  always_ff @(posedge CLK)
  begin
    if (accept && !req.we)
    begin
      case (req.adr)
        `ADDR_RESULT: rdData <= resultReg;
        `ADDR_STATUS: rdData <= status;
        default: rdData <= '0; // CTRL and SAMPLE read as zero
      endcase
    end
  end

  a_singleAck: assert property (
    @(posedge CLK) disable iff (ARST) rsp.ack |=> !rsp.ack
  ) else $error("ack held for two cycles");

endmodule

`default_nettype wire

//--- hw/rotatorTop.sv
`default_nettype none

`include "rotator_settings.svh"

module rotatorTop
(
  input wire logic CLK,
  input wire logic ARST,
  input rotatorPkg::wbReq req,
  output rotatorPkg::wbRsp rsp
);

  import rotatorPkg::*;

  cplxSample sample;
  cplxSample result;
  twiddle tw;
  logic sampleValid;
  logic resultValid;
  logic busy;
  logic advance;
  logic clearIndex;
  logic [`INDEX_WIDTH-1:0] index;

  wbRegs regs
  (
    .CLK(CLK),
    .ARST(ARST),
    .req(req),
    .rsp(rsp),
    .index(index),
    .result(result),
    .resultValid(resultValid),
    .busy(busy),
    .sample(sample),
    .sampleValid(sampleValid),
    .clearIndex(clearIndex)
  );

  twiddleSequencer seq
  (
    .CLK(CLK),
    .ARST(ARST),
    .advance(advance),
    .clearIndex(clearIndex),
    .index(index)
  );

  // ROM output lags index by one edge
  twiddleRom rom
  (
    .CLK(CLK),
    .ARST(ARST),
    .index(index),
    .tw(tw)
  );

  complexRotator rot
  (
    .CLK(CLK),
    .ARST(ARST),
    .sample(sample),
    .sampleValid(sampleValid),
    .tw(tw),
    .result(result),
    .resultValid(resultValid),
    .busy(busy),
    .advance(advance)
  );

endmodule

`default_nettype wire

//--- verif/rotatorTests.svh
`ifndef ROTATOR_TESTS_SVH
`define ROTATOR_TESTS_SVH

  // Reference twiddles in Q1.14
  logic signed [15:0] cosTable [0:`TWIDDLE_COUNT-1] = '{
    16'h4000, 16'h1090, 16'hC894, 16'hD2BF, 16'h2000, 16'h3DD1,
    16'h0000, 16'hC22F, 16'hE001, 16'h2D41, 16'h376C, 16'hEF70,
    16'hC000, 16'hEF70, 16'h376C, 16'h2D41, 16'hE000, 16'hC22F,
    16'h0000, 16'h3DD1, 16'h2000, 16'hD2BF, 16'hC894, 16'h1090};
  logic signed [15:0] sinTable [0:`TWIDDLE_COUNT-1] = '{
    16'h0000, 16'h3DD1, 16'h1FFF, 16'hD2BF, 16'hC894, 16'h1090,
    16'h4000, 16'h1090, 16'hC894, 16'hD2BF, 16'h1FFF, 16'h3DD1,
    16'h0000, 16'hC22F, 16'hE000, 16'h2D41, 16'h376C, 16'hEF70,
    16'hC000, 16'hEF70, 16'h376C, 16'h2D41, 16'hE001, 16'hC22F};

  int expIndex; // Table entry the next sample should use

  function automatic logic signed [15:0] clip(input longint value);
    if (value > 32767)
      return 16'h7FFF;
    else if (value < -32768)
      return 16'h8000;
    else
      return value[15:0];
  endfunction

  // Multiply by cos - j*sin, truncate the Q1.14 scale, then clip
  function automatic cplxSample expectedRotation(input cplxSample s, input int idx);
    longint a;
    longint b;
    longint c;
    longint sn;
    cplxSample r;
    a = s.re;
    b = s.im;
    c = cosTable[idx];
    sn = sinTable[idx];
    r.re = clip((a * c + b * sn) >>> `FRAC_BITS);
    r.im = clip((b * c - a * sn) >>> `FRAC_BITS);
    return r;
  endfunction

  function automatic statusWord idleStatus(input int idx);
    statusWord st;
    st = '0;
    st.index = idx[`INDEX_WIDTH-1:0];
    return st;
  endfunction

  task automatic writeSample(input cplxSample s);
    wbWord w;
    w.sample = s;
    wbWrite(`ADDR_SAMPLE, w);
  endtask

  task automatic waitIdle(output statusWord st);
    logic [31:0] data;
    int polls;
    polls = 0;
    do
    begin
      wbRead(`ADDR_STATUS, data);
      st = data;
      polls++;
    end
    while (st.busy && polls < IdlePolls);
    if (st.busy)
    begin
      $display("The DUT stayed busy through %0d status polls", IdlePolls);
      $display("** FAIL **");
      $fatal(1, "rotator never went idle");
    end
  endtask

  task automatic readResult(output cplxSample r);
    logic [31:0] data;
    wbRead(`ADDR_RESULT, data);
    r = data;
  endtask

  task automatic restartIndex(input string testName);
    wbWord w;
    logic [31:0] data;
    w = '0;
    w.ctrl.clearIndex = 1'b1;
    wbWrite(`ADDR_CTRL, w);
    wbRead(`ADDR_STATUS, data);
    checkStatus(testName, idleStatus(0), data);
    expIndex = 0;
  endtask

  // One sample through the pipe, then status and result
  task automatic rotateAndCheck(input string testName, input cplxSample s);
    statusWord st;
    statusWord busyStatus;
    cplxSample r;
    logic [31:0] data;
    int nextIndex;
    nextIndex = (expIndex + 1) % `TWIDDLE_COUNT;
    busyStatus = idleStatus(nextIndex);
    busyStatus.busy = 1'b1;
    writeSample(s);
    wbRead(`ADDR_STATUS, data); // Stage 1 still holds the sample
    checkStatus(testName, busyStatus, data);
    waitIdle(st);
    checkStatus(testName, idleStatus(nextIndex), st);
    readResult(r);
    checkSample(testName, expectedRotation(s, expIndex), r);
    expIndex = nextIndex;
  endtask

  task automatic resetStateTest();
    logic [31:0] data;
    cplxSample r;
    wbRead(`ADDR_STATUS, data);
    checkStatus("resetState", idleStatus(0), data);
    readResult(r);
    checkSample("resetState", '0, r);
  endtask

  task automatic tableSweepTest();
    cplxSample s;
    s.re = 16'sh4000;
    s.im = '0;
    repeat (48) rotateAndCheck("tableSweep", s); // Two passes with wrap
  endtask

  task automatic randomSamplesTest();
    cplxSample s;
    restartIndex("randomSamples");
    repeat (100)
    begin
      s = $random(seed);
      rotateAndCheck("randomSamples", s);
    end
  endtask

  task automatic saturationTest();
    cplxSample s;
    restartIndex("saturation");
    repeat (15) rotateAndCheck("saturation", '0);
    s.re = 16'sh8000;
    s.im = 16'sh8000;
    rotateAndCheck("saturation", s); // Entry 15 overflows the real part
    restartIndex("saturation");
    s.re = 16'sh7FFF;
    s.im = 16'sh8000;
    rotateAndCheck("saturation", s);
    restartIndex("saturation");
    s.re = 16'sh8000;
    s.im = 16'sh7FFF;
    rotateAndCheck("saturation", s);
  endtask

  task automatic indexClearTest();
    cplxSample s;
    restartIndex("indexClear");
    repeat (7)
    begin
      s = $random(seed);
      rotateAndCheck("indexClear", s);
    end
    restartIndex("indexClear");
    s.re = 16'sd1234;
    s.im = -16'sd2345;
    rotateAndCheck("indexClear", s);
  endtask

  task automatic ignoredWriteTest();
    cplxSample first;
    cplxSample second;
    cplxSample r;
    statusWord st;
    int nextIndex;
    first = $random(seed);
    second = $random(seed);
    nextIndex = (expIndex + 1) % `TWIDDLE_COUNT;
    writeSample(first);
    writeSample(second); // Lands while stage 1 is still full
    waitIdle(st);
    checkStatus("ignoredWrite", idleStatus(nextIndex), st);
    readResult(r);
    checkSample("ignoredWrite", expectedRotation(first, expIndex), r);
    expIndex = nextIndex;
    rotateAndCheck("ignoredWrite", second);
  endtask

`endif

//--- verif/rotatorTb.sv
`default_nettype none

`include "rotator_settings.svh"

module rotatorTb;

  import rotatorPkg::*;

  localparam int ClkPeriod = 4;
  localparam int ResetCycles = 8;
  localparam int TotalSamples = 48 + 100 + 18 + 8 + 3;
  localparam int WatchdogTime = TotalSamples * 40 + 2000;
  localparam int AckLimit = 16;
  localparam int IdlePolls = 20;

  logic CLK;
  logic ARST;
  wbReq req;
  wbRsp rsp;
  integer seed;

  rotatorTop uut
  (
    .CLK(CLK),
    .ARST(ARST),
    .req(req),
    .rsp(rsp)
  );

  initial
  begin
    CLK = 1'b0;
    forever
    begin
      #(ClkPeriod / 2) CLK = ~CLK;
    end
  end

  initial
  begin
    #(WatchdogTime);
    $display("Watchdog expired after %0d time units before the tests finished", WatchdogTime);
    $display("** FAIL **");
    $fatal(1, "run stopped by watchdog");
  end

  // Hold the request until ack, then release the bus
  task automatic finishCycle(input string kind);
    int waitCycles;
    waitCycles = 0;
    do
    begin
      @(posedge CLK);
      #1;
      waitCycles++;
    end
    while (!rsp.ack && waitCycles < AckLimit);
    if (!rsp.ack)
    begin
      $display("The DUT never acked a Wishbone %s", kind);
      $display("** FAIL **");
      $fatal(1, "missing ack");
    end
    else
    begin
      req.cyc = 1'b0;
      req.stb = 1'b0;
      req.we = 1'b0;
    end
  endtask

  task automatic wbWrite(input logic [`WB_ADDR_WIDTH-1:0] adr, input wbWord dat);
    @(posedge CLK);
    #1;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we = 1'b1;
    req.adr = adr;
    req.dat = dat;
    finishCycle("write");
  endtask

  task automatic wbRead(input logic [`WB_ADDR_WIDTH-1:0] adr, output logic [31:0] data);
    @(posedge CLK);
    #1;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we = 1'b0;
    req.adr = adr;
    req.dat = '0;
    finishCycle("read");
    data = rsp.dat; // Held until the next read
  endtask

  task automatic checkSample(input string testName, input cplxSample expected,
                             input cplxSample actual);
    if (actual !== expected)
    begin
      $display("** Error %s: expected re=%0d im=%0d, actual re=%0d im=%0d", testName,
               expected.re, expected.im, actual.re, actual.im);
      $display("** FAIL **");
      $fatal(1, "sample mismatch");
    end
  endtask

  task automatic checkStatus(input string testName, input statusWord expected,
                             input statusWord actual);
    if (actual !== expected)
    begin
      $display("** Error %s: expected busy=%0b index=%0d, actual busy=%0b index=%0d (raw %h)",
               testName, expected.busy, expected.index, actual.busy, actual.index, actual);
      $display("** FAIL **");
      $fatal(1, "status mismatch");
    end
  endtask

  `include "rotatorTests.svh"

  initial
  begin
    seed = 32'h5b6bd69a;
    ARST = 1'b1;
    req = '0;
    expIndex = 0;
    repeat (ResetCycles) @(posedge CLK);
    #1;
    ARST = 1'b0;
    resetStateTest();
    tableSweepTest();
    randomSamplesTest();
    saturationTest();
    indexClearTest();
    ignoredWriteTest();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- rotatorTop.f
+incdir+hw
+incdir+verif
hw/rotatorPkg.sv
hw/twiddleRom.sv
hw/twiddleSequencer.sv
hw/complexRotator.sv
hw/wbRegs.sv
hw/rotatorTop.sv
verif/rotatorTb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rotator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f rotatorTop.f --top-module rotatorTb -Mdir obj_dir -o rotatorSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rotatorSim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished cleanly"
exit 0
